// ==== compile.f ====
+incdir+verification
common/rob_pkg.sv
rob/rob_table.sv
rob/rob_ctrl.sv
hdl/retire_unit.sv
hdl/rob_top.sv
verification/rob_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rob_tb
RTL_TOP   ?= rob_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/rob_tb_tasks.svh ====
task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_retire(input int lane);
    rob_pkg::retire_t exp;
    if (expected_q.size() == 0) begin
        fail_run($sformatf("retire lane %0d fired with nothing outstanding", lane));
    end
    exp = expected_q.pop_front();
    check_value($sformatf("retire[%0d].pc", lane), 64'(retire[lane].pc), 64'(exp.pc));
    check_value($sformatf("retire[%0d].data", lane), 64'(retire[lane].data), 64'(exp.data));
    check_value($sformatf("retire[%0d].dest_reg", lane),
                64'(retire[lane].dest_reg), 64'(exp.dest_reg));
    check_value($sformatf("retire[%0d].op_class", lane),
                64'(retire[lane].op_class), 64'(exp.op_class));
endtask

task automatic idle_inputs();
    dispatch      <= '0;
    alu_commit    <= '0;
    mem_commit    <= '0;
    branch_commit <= '0;
    mult_commit   <= '0;
endtask

task automatic record_entry(input rob_pkg::rob_addr_t addr, input rob_pkg::dispatch_t d);
    rob_pkg::retire_t exp;
    exp          = '0;
    exp.valid    = 1'b1;
    exp.op_class = d.op_class;
    exp.dest_reg = d.dest_reg;
    exp.pc       = d.pc;
    exp.data     = $urandom;
    commit_data[addr] = exp.data;
    expected_q.push_back(exp);
    open_q.push_back(addr);
endtask

// starts just after a rising edge and returns at the next falling edge
task automatic send_group(input int lanes, input rob_pkg::op_class_e cls, output int accepted);
    rob_pkg::dispatch_t [rob_pkg::DISPATCH_WIDTH-1:0] grp;
    grp = '0;
    for (int k = 0; k < lanes; k++) begin
        grp[k].valid    = 1'b1;
        grp[k].op_class = cls;
        grp[k].dest_reg = 5'($urandom % 32);
        grp[k].pc       = next_pc + 32'(4 * k);
    end
    dispatch <= grp;
    @(negedge clk);
    accepted = 0;
    got_addr[0] = alloc_addr[0];
    got_addr[1] = alloc_addr[1];
    if (dispatch_ready && lanes > 0) begin
        for (int k = 0; k < lanes; k++) begin
            record_entry(alloc_addr[k], grp[k]);
        end
        accepted = lanes;
        next_pc  = next_pc + 32'(4 * lanes);
    end
endtask

// ports 0 and 1 are ALU and ports 2 to 4 memory, branch and multiply
task automatic put_commit(input int port, input rob_pkg::rob_addr_t addr, input logic exc,
                          input rob_pkg::exc_cause_e cause);
    rob_pkg::commit_t c;
    c           = '0;
    c.valid     = 1'b1;
    c.rob_addr  = addr;
    c.data      = commit_data[addr];
    c.exc_valid = exc;
    c.exc_cause = cause;
    case (port)
        0: alu_commit[0] <= c;
        1: alu_commit[1] <= c;
        2: mem_commit[0] <= c;
        3: branch_commit[0] <= c;
        default: mult_commit[0] <= c;
    endcase
endtask

task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
        @(negedge clk);
        waited++;
        if (waited > 40) begin
            fail_run("outstanding instructions never retired");
        end
    end
endtask

task automatic commit_open_entries();
    int pick;
    while (open_q.size() != 0) begin
        @(posedge clk);
        idle_inputs();
        pick = $urandom % open_q.size();
        put_commit($urandom % 5, open_q[pick], 1'b0, rob_pkg::EXC_NONE);
        open_q.delete(pick);
    end
    @(posedge clk);
    idle_inputs();
    wait_drain();
endtask

task automatic pulse_flush();
    @(posedge clk);
    idle_inputs();
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    expected_q.delete();
    open_q.delete();
endtask

task automatic test_reset_state();
    @(negedge clk);
    check_value("dispatch_ready", 64'(dispatch_ready), 64'd1);
    check_value("retire[0].valid", 64'(retire[0].valid), 64'd0);
    check_value("retire[1].valid", 64'(retire[1].valid), 64'd0);
    check_value("exception.valid", 64'(exception.valid), 64'd0);
    check_value("alloc_addr[0]", 64'(alloc_addr[0]), 64'd0);
    check_value("alloc_addr[1]", 64'(alloc_addr[1]), 64'd1);
endtask

task automatic test_out_of_order();
    int acc;
    rob_pkg::rob_addr_t a [4];
    int ports [4];
    ports = '{2, 4, 3, 1};
    @(posedge clk);
    idle_inputs();
    send_group(2, rob_pkg::OP_ALU, acc);
    @(posedge clk);
    idle_inputs();
    send_group(2, rob_pkg::OP_ALU, acc);
    check_value("open entries", 64'(open_q.size()), 64'd4);
    for (int i = 0; i < 4; i++) begin
        a[i] = open_q[i];
    end
    open_q.delete();
    // youngest first
    for (int i = 3; i >= 0; i--) begin
        @(posedge clk);
        idle_inputs();
        put_commit(ports[i], a[i], 1'b0, rob_pkg::EXC_NONE);
    end
    @(posedge clk);
    idle_inputs();
    wait_drain();
endtask

task automatic test_capacity();
    int acc;
    int count;
    int waited;
    pulse_flush();
    count = 0;
    for (int n = 0; n < 6; n++) begin
        @(posedge clk);
        idle_inputs();
        send_group(2, rob_pkg::OP_ALU, acc);
        if (acc == 0) begin
            break;
        end
        check_value("alloc_addr[0]", 64'(got_addr[0]), 64'(count));
        check_value("alloc_addr[1]", 64'(got_addr[1]), 64'(count + 1));
        count += 2;
    end
    check_value("accepted entries", 64'(count), 64'd8);
    @(posedge clk);
    idle_inputs();
    put_commit(0, open_q[0], 1'b0, rob_pkg::EXC_NONE);
    put_commit(1, open_q[1], 1'b0, rob_pkg::EXC_NONE);
    void'(open_q.pop_front());
    void'(open_q.pop_front());
    waited = 0;
    do begin
        @(posedge clk);
        idle_inputs();
        @(negedge clk);
        waited++;
        if (waited > 10) begin
            fail_run("dispatch_ready stayed low after two entries retired");
        end
    end while (!dispatch_ready);
    @(posedge clk);
    send_group(2, rob_pkg::OP_MULT, acc);
    check_value("wrapped accepted", 64'(acc), 64'd2);
    check_value("alloc_addr[0]", 64'(got_addr[0]), 64'd0);
    check_value("alloc_addr[1]", 64'(got_addr[1]), 64'd1);
    commit_open_entries();
endtask

task automatic test_exception();
    int acc;
    int waited;
    logic [31:0] exc_pc;
    rob_pkg::rob_addr_t a [3];
    @(posedge clk);
    idle_inputs();
    send_group(2, rob_pkg::OP_LOAD, acc);
    @(posedge clk);
    idle_inputs();
    send_group(1, rob_pkg::OP_ALU, acc);
    check_value("open entries", 64'(open_q.size()), 64'd3);
    for (int i = 0; i < 3; i++) begin
        a[i] = open_q[i];
    end
    open_q.delete();
    exc_pc = expected_q[1].pc;
    @(posedge clk);
    idle_inputs();
    put_commit(0, a[0], 1'b0, rob_pkg::EXC_NONE);
    put_commit(2, a[1], 1'b1, rob_pkg::EXC_ILLEGAL);
    @(posedge clk);
    idle_inputs();
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
        if (waited > 10) begin
            fail_run("no exception report after a faulting commit");
        end
    end while (!exception.valid);
    check_value("outstanding after exception", 64'(expected_q.size()), 64'd2);
    check_value("exception.pc", 64'(exception.pc), 64'(exc_pc));
    check_value("exception.cause", 64'(exception.cause), 64'(rob_pkg::EXC_ILLEGAL));
    expected_q.delete();
    @(negedge clk);
    check_value("exception.valid", 64'(exception.valid), 64'd0);
    repeat (3) @(negedge clk);
    check_value("alloc_addr[0]", 64'(alloc_addr[0]), 64'd0);
    check_value("dispatch_ready", 64'(dispatch_ready), 64'd1);
endtask

task automatic test_flush();
    int acc;
    rob_pkg::rob_addr_t a [4];
    @(posedge clk);
    idle_inputs();
    send_group(2, rob_pkg::OP_STORE, acc);
    @(posedge clk);
    idle_inputs();
    send_group(2, rob_pkg::OP_BRANCH, acc);
    for (int i = 0; i < 4; i++) begin
        a[i] = open_q[i];
    end
    open_q.delete();
    // the oldest stays incomplete so nothing retires early
    for (int i = 3; i >= 1; i--) begin
        @(posedge clk);
        idle_inputs();
        put_commit(i + 1, a[i], 1'b0, rob_pkg::EXC_NONE);
    end
    @(posedge clk);
    idle_inputs();
    put_commit(0, a[0], 1'b0, rob_pkg::EXC_NONE);
    flush <= 1'b1;
    @(posedge clk);
    idle_inputs();
    flush <= 1'b0;
    expected_q.delete();
    repeat (4) @(negedge clk);
    check_value("alloc_addr[0]", 64'(alloc_addr[0]), 64'd0);
    check_value("alloc_addr[1]", 64'(alloc_addr[1]), 64'd1);
    check_value("dispatch_ready", 64'(dispatch_ready), 64'd1);
endtask

task automatic test_random();
    int acc;
    int pick;
    int p0;
    int lanes;
    rob_pkg::op_class_e cls;
    for (int c = 0; c < 200; c++) begin
        @(posedge clk);
        idle_inputs();
        if (open_q.size() > 0 && ($urandom % 2) == 1) begin
            pick = $urandom % open_q.size();
            p0   = $urandom % 5;
            put_commit(p0, open_q[pick], 1'b0, rob_pkg::EXC_NONE);
            open_q.delete(pick);
            if (open_q.size() > 0 && ($urandom % 2) == 1) begin
                pick = $urandom % open_q.size();
                put_commit((p0 + 1 + ($urandom % 4)) % 5, open_q[pick], 1'b0,
                           rob_pkg::EXC_NONE);
                open_q.delete(pick);
            end
        end
        lanes   = $urandom % 3;
        cls     = rob_pkg::op_class_e'(3'($urandom % 5));
        next_pc = $urandom & 32'hffff_fffc;
        send_group(lanes, cls, acc);
    end
    commit_open_entries();
endtask

// ==== verification/rob_tb.sv ====
`timescale 1ns/10ps

module rob_tb;

    localparam int CYCLE_LIMIT = 3000;

    logic                                              clk;
    logic                                              reset;
    logic                                              flush;
    rob_pkg::dispatch_t [rob_pkg::DISPATCH_WIDTH-1:0]  dispatch;
    logic                                              dispatch_ready;
    rob_pkg::rob_addr_t [rob_pkg::DISPATCH_WIDTH-1:0]  alloc_addr;
    rob_pkg::commit_t [rob_pkg::ALU_NUM-1:0]           alu_commit;
    rob_pkg::commit_t [rob_pkg::MEM_NUM-1:0]           mem_commit;
    rob_pkg::commit_t [rob_pkg::BRANCH_NUM-1:0]        branch_commit;
    rob_pkg::commit_t [rob_pkg::MULT_NUM-1:0]          mult_commit;
    rob_pkg::retire_t [rob_pkg::RETIRE_WIDTH-1:0]      retire;
    rob_pkg::exception_t                               exception;

    int                 cycle_count;
    logic [31:0]        next_pc;
    logic [31:0]        commit_data [rob_pkg::ROB_DEPTH];
    rob_pkg::rob_addr_t got_addr [rob_pkg::DISPATCH_WIDTH];

    // retire packets still expected in program order
    rob_pkg::retire_t   expected_q [$];
    // allocated entries not yet completed
    rob_pkg::rob_addr_t open_q [$];

    rob_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .alloc_addr     (alloc_addr),
        .alu_commit     (alu_commit),
        .mem_commit     (mem_commit),
        .branch_commit  (branch_commit),
        .mult_commit    (mult_commit),
        .retire         (retire),
        .exception      (exception)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    `include "rob_tb_tasks.svh"

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run("simulation ran past the cycle limit");
        end
    end

    // pulses launched at the previous edge
    always @(posedge clk) begin
        if (!reset) begin
            for (int k = 0; k < rob_pkg::RETIRE_WIDTH; k++) begin
                if (retire[k].valid) begin
                    check_retire(k);
                end
            end
        end
    end

    initial begin
        void'($urandom(44));
        reset       = 1'b1;
        flush       = 1'b0;
        dispatch    = '0;
        alu_commit  = '0;
        mem_commit  = '0;
        branch_commit = '0;
        mult_commit = '0;
        cycle_count = 0;
        next_pc     = 32'h0000_1000;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_out_of_order();
        test_capacity();
        test_exception();
        test_flush();
        test_random();

        repeat (4) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== hdl/rob_top.sv ====
`timescale 1ns/10ps

module rob_top (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             flush,
    input  rob_pkg::dispatch_t [rob_pkg::DISPATCH_WIDTH-1:0] dispatch,
    output logic                                             dispatch_ready,
    output rob_pkg::rob_addr_t [rob_pkg::DISPATCH_WIDTH-1:0] alloc_addr,
    input  rob_pkg::commit_t [rob_pkg::ALU_NUM-1:0]          alu_commit,
    input  rob_pkg::commit_t [rob_pkg::MEM_NUM-1:0]          mem_commit,
    input  rob_pkg::commit_t [rob_pkg::BRANCH_NUM-1:0]       branch_commit,
    input  rob_pkg::commit_t [rob_pkg::MULT_NUM-1:0]         mult_commit,
    output rob_pkg::retire_t [rob_pkg::RETIRE_WIDTH-1:0]     retire,
    output rob_pkg::exception_t                              exception
);

    logic [rob_pkg::DISPATCH_WIDTH-1:0]           dispatch_valid;
    logic [rob_pkg::DISPATCH_WIDTH-1:0]           alloc_en;
    rob_pkg::rob_addr_t                           head_addr;
    rob_pkg::rob_addr_t                           tail_addr;
    logic                                         kill;
    logic [1:0]                                   retire_count;
    logic                                         exc_detect;
    rob_pkg::entry_t [rob_pkg::RETIRE_WIDTH-1:0]  head_window;

    genvar g;
    generate
        for (g = 0; g < rob_pkg::DISPATCH_WIDTH; g++) begin : g_valid
            assign dispatch_valid[g] = dispatch[g].valid;
        end
    endgenerate

    rob_table i_table (
        .clk           (clk),
        .reset         (reset),
        .dispatch      (dispatch),
        .alloc_en      (alloc_en),
        .tail_addr     (tail_addr),
        .head_addr     (head_addr),
        .alu_commit    (alu_commit),
        .mem_commit    (mem_commit),
        .branch_commit (branch_commit),
        .mult_commit   (mult_commit),
        .kill          (kill),
        .head_window   (head_window)
    );

    rob_ctrl i_ctrl (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .retire_count   (retire_count),
        .exc_detect     (exc_detect),
        .dispatch_ready (dispatch_ready),
        .alloc_en       (alloc_en),
        .alloc_addr     (alloc_addr),
        .head_addr      (head_addr),
        .tail_addr      (tail_addr),
        .kill           (kill)
    );

    retire_unit i_retire (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .head_window  (head_window),
        .retire_count (retire_count),
        .exc_detect   (exc_detect),
        .retire       (retire),
        .exception    (exception)
    );

endmodule

// ==== hdl/retire_unit.sv ====
`timescale 1ns/10ps

module retire_unit (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        flush,
    input  rob_pkg::entry_t [rob_pkg::RETIRE_WIDTH-1:0] head_window,
    output logic [1:0]                                  retire_count,
    output logic                                        exc_detect,
    output rob_pkg::retire_t [rob_pkg::RETIRE_WIDTH-1:0] retire,
    output rob_pkg::exception_t                         exception
);

    logic [rob_pkg::RETIRE_WIDTH-1:0]             slot_ok;
    logic [rob_pkg::RETIRE_WIDTH-1:0]             slot_retire;
    rob_pkg::retire_t [rob_pkg::RETIRE_WIDTH-1:0] retire_d;

    always_comb begin
        for (int k = 0; k < rob_pkg::RETIRE_WIDTH; k++) begin
            slot_ok[k] = head_window[k].busy && head_window[k].complete &&
                         !head_window[k].exc_valid;
        end

        // a slot retires only behind the one before it
        slot_retire[0] = slot_ok[0];
        for (int k = 1; k < rob_pkg::RETIRE_WIDTH; k++) begin
            slot_retire[k] = slot_retire[k-1] && slot_ok[k];
        end

        retire_count = '0;
        for (int k = 0; k < rob_pkg::RETIRE_WIDTH; k++) begin
            retire_count = retire_count + 2'(slot_retire[k]);
        end

        for (int k = 0; k < rob_pkg::RETIRE_WIDTH; k++) begin
            retire_d[k] = '0;
            if (slot_retire[k]) begin
                retire_d[k].valid    = 1'b1;
                retire_d[k].op_class = head_window[k].op_class;
                retire_d[k].dest_reg = head_window[k].dest_reg;
                retire_d[k].pc       = head_window[k].pc;
                retire_d[k].data     = head_window[k].data;
            end
        end
    end

    // faulting instruction at the head
    assign exc_detect = head_window[0].busy && head_window[0].complete &&
                        head_window[0].exc_valid;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            retire    <= '0;
            exception <= '0;
        end else begin
            retire          <= retire_d;
            exception.valid <= exc_detect;
            if (exc_detect) begin
                exception.pc    <= head_window[0].pc;
                exception.cause <= head_window[0].exc_cause;
            end
        end
    end

endmodule

// ==== rob/rob_ctrl.sv ====
`timescale 1ns/10ps

module rob_ctrl (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             flush,
    input  logic [rob_pkg::DISPATCH_WIDTH-1:0]               dispatch_valid,
    input  logic [1:0]                                       retire_count,
    input  logic                                             exc_detect,
    output logic                                             dispatch_ready,
    output logic [rob_pkg::DISPATCH_WIDTH-1:0]               alloc_en,
    output rob_pkg::rob_addr_t [rob_pkg::DISPATCH_WIDTH-1:0] alloc_addr,
    output rob_pkg::rob_addr_t                               head_addr,
    output rob_pkg::rob_addr_t                               tail_addr,
    output logic                                             kill
);

    rob_pkg::rob_ptr_t head_ptr;
    rob_pkg::rob_ptr_t tail_ptr;
    rob_pkg::rob_ptr_t used_count;
    rob_pkg::rob_ptr_t free_count;
    rob_pkg::rob_ptr_t alloc_num;
    rob_pkg::rob_ptr_t head_step;
    logic              full;
    logic              empty;

    assign head_addr = head_ptr[rob_pkg::ROB_ADDR_LEN-1:0];
    assign tail_addr = tail_ptr[rob_pkg::ROB_ADDR_LEN-1:0];

    assign kill = flush | exc_detect;

    // full when the indexes match and the wrap bits differ
    assign full  = (head_ptr[rob_pkg::ROB_ADDR_LEN] != tail_ptr[rob_pkg::ROB_ADDR_LEN]) &&
                   (head_addr == tail_addr);
    assign empty = (head_ptr == tail_ptr);

    assign used_count = full ? rob_pkg::rob_ptr_t'(rob_pkg::ROB_DEPTH)
                             : {1'b0, tail_addr - head_addr};
    assign free_count = rob_pkg::rob_ptr_t'(rob_pkg::ROB_DEPTH) - used_count;

    // room for a whole dispatch group and no kill
    assign dispatch_ready = ~kill &&
                            (free_count >= rob_pkg::rob_ptr_t'(rob_pkg::DISPATCH_WIDTH));
    assign alloc_en = dispatch_valid & {rob_pkg::DISPATCH_WIDTH{dispatch_ready}};

    genvar g;
    generate
        for (g = 0; g < rob_pkg::DISPATCH_WIDTH; g++) begin : g_alloc
            assign alloc_addr[g] = tail_addr + rob_pkg::rob_addr_t'(g);
        end
    endgenerate

    always_comb begin
        alloc_num = '0;
        for (int i = 0; i < rob_pkg::DISPATCH_WIDTH; i++) begin
            alloc_num = alloc_num + rob_pkg::rob_ptr_t'(alloc_en[i]);
        end
    end

    // nothing to retire past an empty buffer
    assign head_step = empty ? '0 : rob_pkg::rob_ptr_t'(retire_count);

    always_ff @(posedge clk) begin
        if (reset || kill) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + head_step;
            tail_ptr <= tail_ptr + alloc_num;
        end
    end

endmodule

// ==== rob/rob_table.sv ====
`timescale 1ns/10ps

module rob_table (
    input  logic                                             clk,
    input  logic                                             reset,
    input  rob_pkg::dispatch_t [rob_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  logic [rob_pkg::DISPATCH_WIDTH-1:0]               alloc_en,
    input  rob_pkg::rob_addr_t                               tail_addr,
    input  rob_pkg::rob_addr_t                               head_addr,
    input  rob_pkg::commit_t [rob_pkg::ALU_NUM-1:0]          alu_commit,
    input  rob_pkg::commit_t [rob_pkg::MEM_NUM-1:0]          mem_commit,
    input  rob_pkg::commit_t [rob_pkg::BRANCH_NUM-1:0]       branch_commit,
    input  rob_pkg::commit_t [rob_pkg::MULT_NUM-1:0]         mult_commit,
    input  logic                                             kill,
    output rob_pkg::entry_t [rob_pkg::RETIRE_WIDTH-1:0]      head_window
);

    rob_pkg::entry_t [rob_pkg::ROB_DEPTH-1:0]      entries_q;
    rob_pkg::entry_t [rob_pkg::ROB_DEPTH-1:0]      entries_d;
    rob_pkg::commit_t [rob_pkg::COMMIT_NUM-1:0]    commit_all;
    rob_pkg::rob_addr_t [rob_pkg::DISPATCH_WIDTH-1:0] write_addr;
    rob_pkg::rob_addr_t [rob_pkg::RETIRE_WIDTH-1:0]   release_addr;
    rob_pkg::rob_addr_t                            prev_head;
    rob_pkg::rob_addr_t                            retired_num;

    // all completion reports handled alike
    assign commit_all = {mult_commit, branch_commit, mem_commit, alu_commit};

    // head moved by this much at the last edge
    assign retired_num = head_addr - prev_head;

    genvar g;
    generate
        for (g = 0; g < rob_pkg::DISPATCH_WIDTH; g++) begin : g_wr_addr
            assign write_addr[g] = tail_addr + rob_pkg::rob_addr_t'(g);
        end
        for (g = 0; g < rob_pkg::RETIRE_WIDTH; g++) begin : g_window
            assign release_addr[g] = prev_head + rob_pkg::rob_addr_t'(g);
            assign head_window[g]  = entries_q[head_addr + rob_pkg::rob_addr_t'(g)];
        end
    endgenerate

    always_comb begin
        entries_d = entries_q;

        // free the slots the head stepped over
        for (int k = 0; k < rob_pkg::RETIRE_WIDTH; k++) begin
            if (rob_pkg::rob_addr_t'(k) < retired_num) begin
                entries_d[release_addr[k]] = '0;
            end
        end

        // new instructions at the tail
        for (int i = 0; i < rob_pkg::DISPATCH_WIDTH; i++) begin
            if (alloc_en[i]) begin
                entries_d[write_addr[i]].busy      = 1'b1;
                entries_d[write_addr[i]].op_class  = dispatch[i].op_class;
                entries_d[write_addr[i]].dest_reg  = dispatch[i].dest_reg;
                entries_d[write_addr[i]].pc        = dispatch[i].pc;
                entries_d[write_addr[i]].data      = '0;
                entries_d[write_addr[i]].complete  = 1'b0;
                entries_d[write_addr[i]].exc_valid = 1'b0;
                entries_d[write_addr[i]].exc_cause = rob_pkg::EXC_NONE;
            end
        end

        // completions in any order
        for (int p = 0; p < rob_pkg::COMMIT_NUM; p++) begin
            if (commit_all[p].valid) begin
                entries_d[commit_all[p].rob_addr].data      = commit_all[p].data;
                entries_d[commit_all[p].rob_addr].complete  = 1'b1;
                entries_d[commit_all[p].rob_addr].exc_valid = commit_all[p].exc_valid;
                entries_d[commit_all[p].rob_addr].exc_cause = commit_all[p].exc_cause;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || kill) begin
            entries_q <= '0;
            prev_head <= '0;
        end else begin
            entries_q <= entries_d;
            prev_head <= head_addr;
        end
    end

endmodule

// ==== common/rob_pkg.sv ====
package rob_pkg;

    localparam int ROB_DEPTH      = 8;
    localparam int ROB_ADDR_LEN   = 3;
    localparam int DISPATCH_WIDTH = 2;
    localparam int RETIRE_WIDTH   = 2;

    // commit ports per unit class
    localparam int ALU_NUM    = 2;
    localparam int MEM_NUM    = 1;
    localparam int BRANCH_NUM = 1;
    localparam int MULT_NUM   = 1;
    localparam int COMMIT_NUM = ALU_NUM + MEM_NUM + BRANCH_NUM + MULT_NUM;

    typedef logic [ROB_ADDR_LEN-1:0] rob_addr_t;
    // index with the wrap bit on top
    typedef logic [ROB_ADDR_LEN:0] rob_ptr_t;

    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_MULT   = 3'd4
    } op_class_e;

    typedef enum logic [3:0] {
        EXC_NONE         = 4'd0,
        EXC_MISALIGNED   = 4'd1,
        EXC_ACCESS_FAULT = 4'd2,
        EXC_ILLEGAL      = 4'd3,
        EXC_OVERFLOW     = 4'd4
    } exc_cause_e;

    typedef struct packed {
        logic        valid;
        op_class_e   op_class;
        logic [4:0]  dest_reg;
        logic [31:0] pc;
    } dispatch_t;

    typedef struct packed {
        logic        valid;
        rob_addr_t   rob_addr;
        logic [31:0] data;
        logic        exc_valid;
        exc_cause_e  exc_cause;
    } commit_t;

    typedef struct packed {
        logic        busy;
        op_class_e   op_class;
        logic [4:0]  dest_reg;
        logic [31:0] pc;
        logic [31:0] data;
        logic        complete;
        logic        exc_valid;
        exc_cause_e  exc_cause;
    } entry_t;

    typedef struct packed {
        logic        valid;
        op_class_e   op_class;
        logic [4:0]  dest_reg;
        logic [31:0] pc;
        logic [31:0] data;
    } retire_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        exc_cause_e  cause;
    } exception_t;

endpackage
